//--- adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

  // raw converter resolution
  localparam int SAMPLE_W = 16;

  // four converter samples share one 64-bit stream beat
  localparam int SAMPLES_PER_BEAT = 4;
  localparam int BEAT_W = SAMPLE_W * SAMPLES_PER_BEAT;

  // beats per DMA burst, the final one carries last
  localparam int BURST_LEN = 16;

  // capture buffer depth in beats
  localparam int FIFO_DEPTH = 32;

  // frame length and window bounds are counted in clock cycles
  localparam int FRAME_POS_W = 16;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // the oldest sample sits in the low bits
  typedef logic [BEAT_W-1:0] beat_t;

  typedef logic [FRAME_POS_W-1:0] frame_pos_t;

  // one buffered stream entry, beat plus end-of-burst marker
  typedef struct packed {
    beat_t data;
    logic  last;
  } stream_entry_t;

endpackage

`default_nettype wire

//--- axis_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axis_if;
  import adc_capture_pkg::*;

  logic  valid;
  logic  ready;
  beat_t data;
  logic  last;

  // the source holds valid, data and last stable until ready is seen
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

//--- adc_sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sample_packer (
  input  logic                     axis_aclk,
  input  logic                     reset,
  input  logic                     sample_valid,
  input  adc_capture_pkg::sample_t sample,
  axis_if.source                   out
);
  import adc_capture_pkg::*;

  logic [$clog2(SAMPLES_PER_BEAT)-1:0] sample_cnt;
  logic [$clog2(BURST_LEN)-1:0]        burst_cnt;
  beat_t                               beat;
  logic                                beat_valid;
  logic                                beat_last;
  logic                                beat_done;

  // the fourth sample of a group completes the beat on this strobe
  assign beat_done = sample_valid && (sample_cnt == SAMPLES_PER_BEAT - 1);

  // new samples enter at the top so the first one ends up in the low bits
  always_ff @(posedge axis_aclk) begin
    if (sample_valid) begin
      beat <= {sample, beat[BEAT_W-1:SAMPLE_W]};
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      sample_cnt <= '0;
    end else if (sample_valid) begin
      if (beat_done) begin
        sample_cnt <= '0;
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  // burst position advances once per emitted beat
  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      burst_cnt  <= '0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= beat_done;
      if (beat_done) begin
        beat_last <= (burst_cnt == BURST_LEN - 1);
        if (burst_cnt == BURST_LEN - 1) begin
          burst_cnt <= '0;
        end else begin
          burst_cnt <= burst_cnt + 1'b1;
        end
      end
    end
  end

  // the converter cannot stall, so ready is never consulted here
  assign out.valid = beat_valid;
  assign out.data  = beat;
  assign out.last  = beat_last;

endmodule

`default_nettype wire

//--- axis_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_fifo #(
  parameter type payload_t = adc_capture_pkg::stream_entry_t,
  parameter int  DEPTH     = adc_capture_pkg::FIFO_DEPTH
) (
  input  logic   axis_aclk,
  input  logic   reset,
  axis_if.sink   in,
  axis_if.source out,
  output logic   overflow
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;
  payload_t         rd_entry;

  assign full  = (count == CNT_W'(DEPTH));
  assign wr_en = in.valid && in.ready;
  assign rd_en = out.valid && out.ready;

  assign in.ready = !full;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= payload_t'({in.data, in.last});
    end
  end

  // first-word fall-through, the head entry is visible without a read strobe
  assign rd_entry  = mem[rd_ptr];
  assign out.valid = (count != '0);
  assign {out.data, out.last} = rd_entry;

  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // a beat offered while full is lost, flag it until the next reset
  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (in.valid && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- tdd_frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tdd_frame_timer (
  input  logic                        axis_aclk,
  input  logic                        reset,
  input  logic                        tdd_enable,
  input  adc_capture_pkg::frame_pos_t frame_len,
  input  adc_capture_pkg::frame_pos_t on_start,
  input  adc_capture_pkg::frame_pos_t on_end,
  output logic                        tdd_active
);
  import adc_capture_pkg::*;

  frame_pos_t frame_cnt;
  logic       frame_wrap;
  logic       in_window;

  // also wrap if frame_len was shortened below the current position
  assign frame_wrap = (frame_cnt >= frame_len - 1'b1);

  // receive window covers on_start up to but not including on_end
  assign in_window = (frame_cnt >= on_start) && (frame_cnt < on_end);

  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      frame_cnt <= '0;
    end else if (!tdd_enable) begin
      frame_cnt <= '0;
    end else if (frame_wrap) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // registered, so the level trails the counter position by one cycle
  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      tdd_active <= 1'b0;
    end else begin
      tdd_active <= tdd_enable && in_window;
    end
  end

endmodule

`default_nettype wire

//--- dma_interceptor.sv
`timescale 1ns/1ps
`default_nettype none

module dma_interceptor (
  input  logic   axis_aclk,
  input  logic   reset,
  input  logic   enable,
  input  logic   tdd_active,
  axis_if.sink   s_axis,
  axis_if.source m_axis,
  output logic   adc_dma_sync
);

  logic [2:0] enable_pipe;
  logic       enable_sync;
  logic       tdd_active_d;
  logic       running;
  logic       gate;

  // enable may come from a slow control source in another clock domain
  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      enable_pipe <= 3'b000;
    end else begin
      enable_pipe <= {enable_pipe[1:0], enable};
    end
  end

  assign enable_sync = enable_pipe[2];

  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      tdd_active_d <= 1'b0;
    end else begin
      tdd_active_d <= tdd_active;
    end
  end

  // a burst may start once the window is seen and runs until its last beat
  always_ff @(posedge axis_aclk) begin
    if (reset) begin
      running <= 1'b0;
    end else if (!running) begin
      running <= tdd_active;
    end else if (s_axis.valid && s_axis.ready && s_axis.last) begin
      running <= 1'b0;
    end
  end

  // with capture disabled the stream flows freely
  assign gate = !enable_sync || running;

  // sync is held while disabled and pulses on each window start
  assign adc_dma_sync = !enable_sync || (tdd_active && !tdd_active_d);

  assign s_axis.ready = m_axis.ready && gate;
  assign m_axis.valid = s_axis.valid && gate;
  assign m_axis.data  = s_axis.data;
  assign m_axis.last  = s_axis.last;

endmodule

`default_nettype wire

//--- adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top (
  input  logic                        axis_aclk,
  input  logic                        reset,

  input  logic                        sample_valid,
  input  adc_capture_pkg::sample_t    sample,

  input  logic                        enable,
  input  logic                        tdd_enable,
  input  adc_capture_pkg::frame_pos_t frame_len,
  input  adc_capture_pkg::frame_pos_t on_start,
  input  adc_capture_pkg::frame_pos_t on_end,

  output logic                        m_axis_valid,
  input  logic                        m_axis_ready,
  output adc_capture_pkg::beat_t      m_axis_data,
  output logic                        m_axis_last,

  output logic                        adc_dma_sync,
  output logic                        tdd_active,
  output logic                        fifo_overflow
);
  import adc_capture_pkg::*;

  axis_if pack_to_fifo ();
  axis_if fifo_to_gate ();
  // interceptor output, flattened onto the m_axis ports below
  axis_if gate_to_out ();

  adc_sample_packer u_packer (
    .axis_aclk    (axis_aclk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample       (sample),
    .out          (pack_to_fifo.source)
  );

  axis_fifo #(
    .payload_t (stream_entry_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_fifo (
    .axis_aclk (axis_aclk),
    .reset     (reset),
    .in        (pack_to_fifo.sink),
    .out       (fifo_to_gate.source),
    .overflow  (fifo_overflow)
  );

  tdd_frame_timer u_frame_timer (
    .axis_aclk  (axis_aclk),
    .reset      (reset),
    .tdd_enable (tdd_enable),
    .frame_len  (frame_len),
    .on_start   (on_start),
    .on_end     (on_end),
    .tdd_active (tdd_active)
  );

  dma_interceptor u_interceptor (
    .axis_aclk    (axis_aclk),
    .reset        (reset),
    .enable       (enable),
    .tdd_active   (tdd_active),
    .s_axis       (fifo_to_gate.sink),
    .m_axis       (gate_to_out.source),
    .adc_dma_sync (adc_dma_sync)
  );

  assign m_axis_valid      = gate_to_out.valid;
  assign m_axis_data       = gate_to_out.data;
  assign m_axis_last       = gate_to_out.last;
  assign gate_to_out.ready = m_axis_ready;

endmodule

`default_nettype wire

//--- tb_adc_capture_props.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture_props (
  input logic axis_aclk,
  input logic reset,
  input logic enable,
  input logic running,
  input logic xfer,
  input logic xfer_last,
  input logic tdd_active,
  input logic adc_dma_sync
);

  // a handshake toward the DMA needs capture disabled three cycles earlier or a started burst
  gate_closed_no_xfer: assert property (@(posedge axis_aclk) disable iff (reset)
    xfer |-> !$past(enable, 3) || running)
    else $error("transfer while the burst gate is closed");

  // only the last beat of a burst ends it
  running_until_last: assert property (@(posedge axis_aclk) disable iff (reset)
    running && !xfer_last |=> running)
    else $error("running dropped before the last beat of the burst");

  sync_on_window_start: assert property (@(posedge axis_aclk) disable iff (reset)
    $rose(tdd_active) |-> adc_dma_sync)
    else $error("no sync pulse at the start of a receive window");

endmodule

bind dma_interceptor tb_adc_capture_props u_props (
  .axis_aclk    (axis_aclk),
  .reset        (reset),
  .enable       (enable),
  .running      (running),
  .xfer         (s_axis.valid && s_axis.ready),
  .xfer_last    (s_axis.valid && s_axis.ready && s_axis.last),
  .tdd_active   (tdd_active),
  .adc_dma_sync (adc_dma_sync)
);

`default_nettype wire

//--- tb_adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;
  import adc_capture_pkg::*;

  // the six tests need roughly two thousand cycles together
  localparam int TIMEOUT_CYCLES = 20000;

  logic        axis_aclk, reset, sample_valid, enable, tdd_enable, m_axis_ready;
  sample_t     sample;
  frame_pos_t  frame_len, on_start, on_end;
  logic        m_axis_valid, m_axis_last, adc_dma_sync, tdd_active, fifo_overflow;
  beat_t       m_axis_data;
  logic [31:0] rng;
  int          errors, err_base, tests, next_sample, rx_count, cycle_cnt, rises;
  int          active_cycles;
  logic        window_check, sync_hold_check, armed, prev_active;
  string       test_name;

  adc_capture_top u_dut (.*);

  always #50 axis_aclk = ~axis_aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // beat k holds samples 4k to 4k+3 of the counting sequence with the oldest in the low bits
  function automatic beat_t expected_beat(input int k);
    beat_t b;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
      b[i*SAMPLE_W +: SAMPLE_W] = sample_t'(k * SAMPLES_PER_BEAT + i);
    end
    return b;
  endfunction

  function automatic logic expected_last(input int k);
    return ((k + 1) % BURST_LEN) == 0;
  endfunction

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base = errors;
  endtask

  task automatic report_test();
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, test_name,
             (errors == err_base) ? "ok" : "failed", errors - err_base);
  endtask

  // one strobe per sample with a random idle gap, then optionally wait for all beats
  task automatic send_beats(input int beats, input int max_gap, input logic rand_ready,
                            input logic drain);
    int gap;
    int left;
    gap = 0;
    left = beats * SAMPLES_PER_BEAT;
    while (left > 0) begin
      @(negedge axis_aclk);
      rng = xorshift32(rng);
      if (rand_ready) begin
        m_axis_ready = rng[8];
      end
      if (gap == 0) begin
        sample_valid = 1'b1;
        sample = sample_t'(next_sample);
        next_sample++;
        left--;
        gap = int'(rng[7:0]) % (max_gap + 1);
      end else begin
        sample_valid = 1'b0;
        gap--;
      end
    end
    @(negedge axis_aclk);
    sample_valid = 1'b0;
    while (drain && rx_count < next_sample / SAMPLES_PER_BEAT) begin
      @(negedge axis_aclk);
      if (rand_ready) begin
        rng = xorshift32(rng);
        m_axis_ready = rng[8];
      end
    end
  endtask

  // compares every output handshake with the reference sequence
  always @(posedge axis_aclk) begin
    if (reset) begin
      armed <= 1'b0;
    end else begin
      if (m_axis_valid && m_axis_ready) begin
        if (window_check && !armed) begin
          errors++;
          $display("%s: beat %0d left before any receive window opened", test_name, rx_count);
        end
        check_beat({test_name, " data"}, expected_beat(rx_count), m_axis_data);
        check_bit({test_name, " last"}, expected_last(rx_count), m_axis_last);
        rx_count++;
      end
      // a window arms the burst gate and the last beat of a burst closes it again
      if (!armed) begin
        armed <= tdd_active;
      end else if (m_axis_valid && m_axis_ready && m_axis_last) begin
        armed <= 1'b0;
      end
      if (sync_hold_check) begin
        check_bit({test_name, " sync"}, 1'b1, adc_dma_sync);
      end
    end
  end

  always @(posedge axis_aclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout in %s after %0d cycles, %0d beats received", test_name, cycle_cnt,
               rx_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    axis_aclk = 1'b0;
    reset = 1'b1;
    sample_valid = 1'b0;
    sample = '0;
    enable = 1'b0;
    tdd_enable = 1'b0;
    frame_len = '0;
    on_start = '0;
    on_end = '0;
    m_axis_ready = 1'b0;
    rng = 32'd24732;
    errors = 0;
    tests = 0;
    next_sample = 0;
    rx_count = 0;
    cycle_cnt = 0;
    window_check = 1'b0;
    sync_hold_check = 1'b0;
    start_test("reset");
    repeat (16) @(negedge axis_aclk);
    reset = 1'b0;

    start_test("pass_through");
    m_axis_ready = 1'b1;
    sync_hold_check = 1'b1;
    send_beats(2 * BURST_LEN, 2, 1'b0, 1'b1);
    sync_hold_check = 1'b0;
    report_test();

    // enable passes three flops before it closes the gate
    start_test("enable_latency");
    @(negedge axis_aclk);
    enable = 1'b1;
    repeat (2) begin
      @(negedge axis_aclk);
      check_bit("enable_latency sync", 1'b1, adc_dma_sync);
    end
    @(negedge axis_aclk);
    check_bit("enable_latency sync", 1'b0, adc_dma_sync);
    window_check = 1'b1;
    report_test();

    start_test("windowed_bursts");
    frame_len = frame_pos_t'(100);
    on_start = frame_pos_t'(10);
    on_end = frame_pos_t'(70);
    tdd_enable = 1'b1;
    send_beats(3 * BURST_LEN, 2, 1'b0, 1'b1);
    report_test();

    start_test("sync_pulse");
    rises = 0;
    active_cycles = 0;
    @(posedge axis_aclk);
    prev_active = tdd_active;
    // three whole frames hold three window starts and three full windows at any phase
    repeat (3 * int'(frame_len)) begin
      @(posedge axis_aclk);
      check_bit("sync_pulse sync", tdd_active && !prev_active, adc_dma_sync);
      if (tdd_active && !prev_active) begin
        rises++;
      end
      if (tdd_active) begin
        active_cycles++;
      end
      prev_active = tdd_active;
    end
    if (rises != 3) begin
      errors++;
      $display("** Error sync_pulse window starts: expected 3, actual %0d", rises);
    end
    if (active_cycles != 3 * (int'(on_end) - int'(on_start))) begin
      errors++;
      $display("** Error sync_pulse window cycles: expected %0d, actual %0d",
               3 * (int'(on_end) - int'(on_start)), active_cycles);
    end
    report_test();

    start_test("back_pressure");
    send_beats(3 * BURST_LEN, 2, 1'b1, 1'b1);
    m_axis_ready = 1'b1;
    check_bit("back_pressure overflow", 1'b0, fifo_overflow);
    report_test();

    // the output is stalled, so the FIFO fills and then drops beats
    start_test("overflow");
    m_axis_ready = 1'b0;
    send_beats(FIFO_DEPTH + 8, 0, 1'b0, 1'b0);
    repeat (2) @(negedge axis_aclk);
    check_bit("overflow flag", 1'b1, fifo_overflow);
    repeat (20) @(negedge axis_aclk);
    check_bit("overflow flag held", 1'b1, fifo_overflow);
    reset = 1'b1;
    repeat (2) @(negedge axis_aclk);
    reset = 1'b0;
    @(negedge axis_aclk);
    check_bit("overflow flag after reset", 1'b0, fifo_overflow);
    report_test();

    $display("%0d tests, %0d beats checked, %0d errors", tests, rx_count, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
adc_capture_pkg.sv
axis_if.sv
adc_sample_packer.sv
axis_fifo.sv
tdd_frame_timer.sv
dma_interceptor.sv
adc_capture_top.sv
tb_adc_capture_props.sv
tb_adc_capture.sv

//--- Makefile
SIM      := verilator
TOP      := tb_adc_capture
FILELIST := verilog.f
VFLAGS   := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message appears as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
